/* src/score_pkg.sv */
`default_nettype none

package score_pkg;

	////////////////////////////////
	// sizes
	////////////////////////////////
	localparam int NUM_TARGETS = 14;
	localparam int SCORE_WIDTH = 20;
	localparam int NUM_DIGITS = 5;
	localparam int DIGIT_WIDTH = 4;
	localparam int IDX_WIDTH = $clog2(NUM_TARGETS);

	typedef logic [SCORE_WIDTH-1:0] score_t;
	typedef logic [NUM_TARGETS-1:0] target_mask_t;
	typedef logic [IDX_WIDTH-1:0] target_idx_t;
	typedef logic [DIGIT_WIDTH-1:0] digit_t;
	// most significant digit in the top nibble
	typedef logic [NUM_DIGITS*DIGIT_WIDTH-1:0] bcd_score_t;

	// lane FSM encoding as seen from the game side
	// any value not named here means catches are ignored
	typedef enum logic [2:0] {
		LANE_SCORING = 3'd0,
		LANE_BLOCKED = 3'd3
	} lane_state_t;

	////////////////////////////////
	// tables
	////////////////////////////////
	// points per target, index 0 first
	localparam score_t TARGET_VALUE [NUM_TARGETS] = '{
		20'd500, 20'd500, 20'd250, 20'd250,
		20'd100, 20'd100, 20'd50,  20'd50,
		20'd600, 20'd20,  20'd50,  20'd50,
		20'd20,  20'd20
	};

	// weight of each displayed digit, units first
	localparam score_t DIGIT_WEIGHT [NUM_DIGITS] = '{
		20'd1, 20'd10, 20'd100, 20'd1000, 20'd10000
	};

endpackage

`default_nettype wire

/* src/catch_decode.sv */
`default_nettype none

module catch_decode (
	input  logic                    Clk,
	input  logic                    reset,
	input  logic                    round_start,
	input  score_pkg::target_mask_t catches,
	input  score_pkg::lane_state_t  lane_state,
	output logic                    award_valid,
	output score_pkg::target_idx_t  award_idx,
	output logic                    award_scores
);
	import score_pkg::*;

	target_mask_t claimed;
	target_mask_t pending;
	logic         lane_live;

	////////////////////////////////
	// lane state
	////////////////////////////////
	// blocked lane still uses up targets, scoring lane also earns points
	assign lane_live = (lane_state == LANE_SCORING) || (lane_state == LANE_BLOCKED);
	assign award_scores = (lane_state == LANE_SCORING);

	////////////////////////////////
	// target select
	////////////////////////////////
	// caught and not yet claimed this round
	assign pending = catches & ~claimed;

	// walk down so the lowest index wins
	always_comb begin
		award_valid = 1'b0;
		award_idx = '0;
		for (int i = NUM_TARGETS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				award_valid = lane_live;
				award_idx = target_idx_t'(i);
			end
		end
	end

	////////////////////////////////
	// claimed mask
	////////////////////////////////
	always_ff @(posedge Clk) begin
		if (reset) begin
			claimed <= '0;
		end else if (round_start) begin
			// new round re-arms every target
			claimed <= '0;
		end else if (award_valid) begin
			claimed[award_idx] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/side_score.sv */
`default_nettype none

module side_score (
	input  logic                   Clk,
	input  logic                   reset,
	input  logic                   round_start,
	input  logic                   double_active,
	input  logic                   award_valid,
	input  logic                   award_scores,
	input  score_pkg::target_idx_t award_idx,
	output score_pkg::score_t      score
);
	import score_pkg::*;

	logic   earn;
	score_t award_points;

	// points only count in the scoring lane with double mode on
	assign earn = award_valid && award_scores && double_active;

	// idx is only looked at with a valid award, so it stays in 0..13
	assign award_points = TARGET_VALUE[award_idx];

	////////////////////////////////
	// accumulator
	////////////////////////////////
	always_ff @(posedge Clk) begin
		if (reset) begin
			score <= '0;
		end else if (round_start) begin
			// catches in this cycle are dropped
			score <= '0;
		end else if (earn) begin
			score <= score + award_points;
		end
	end

endmodule

`default_nettype wire

/* src/score_result.sv */
`default_nettype none

module score_result (
	input  logic              Clk,
	input  logic              reset,
	input  logic              round_start,
	input  logic              time_end,
	input  score_pkg::score_t score_left,
	input  score_pkg::score_t score_right,
	input  score_pkg::score_t target_score,
	output score_pkg::score_t total_score,
	output logic              show_fail
);

	logic below_target;

	////////////////////////////////
	// total
	////////////////////////////////
	// total lags the side scores by one edge
	always_ff @(posedge Clk) begin
		if (reset) begin
			total_score <= '0;
		end else if (!round_start) begin
			total_score <= score_left + score_right;
		end
	end

	////////////////////////////////
	// verdict
	////////////////////////////////
	// compares the registered total, not the live sum
	assign below_target = (total_score < target_score);

	always_ff @(posedge Clk) begin
		if (reset) begin
			show_fail <= 1'b0;
		end else begin
			show_fail <= time_end && below_target;
		end
	end

endmodule

`default_nettype wire

/* src/score_digits.sv */
`default_nettype none

module score_digits (
	input  logic                  Clk,
	input  score_pkg::score_t     score,
	output score_pkg::bcd_score_t digits
);
	import score_pkg::*;

	// quot[i] is score / 10^i
	score_t quot [NUM_DIGITS];
	digit_t digit [NUM_DIGITS];

	////////////////////////////////
	// stage one
	////////////////////////////////
	// constant divisors, one per digit weight
	always_ff @(posedge Clk) begin
		for (int i = 0; i < NUM_DIGITS; i++) begin
			quot[i] <= score / DIGIT_WEIGHT[i];
		end
	end

	////////////////////////////////
	// stage two
	////////////////////////////////
	// strip the next weight off each quotient
	always_ff @(posedge Clk) begin
		for (int i = 0; i < NUM_DIGITS - 1; i++) begin
			digit[i] <= digit_t'(quot[i] - score_t'(10) * quot[i+1]);
		end
		// top digit is the quotient itself, wraps past 99999
		digit[NUM_DIGITS-1] <= digit_t'(quot[NUM_DIGITS-1]);
	end

	// pack units into the low nibble
	always_comb begin
		for (int i = 0; i < NUM_DIGITS; i++) begin
			digits[i*DIGIT_WIDTH +: DIGIT_WIDTH] = digit[i];
		end
	end

endmodule

`default_nettype wire

/* src/score_keeper_top.sv */
`default_nettype none

module score_keeper_top (
	input  logic                  Clk,
	input  logic                  reset,
	input  logic                  round_start,
	input  logic                  double_active,
	input  logic                  time_end,
	input  score_pkg::target_mask_t catch_left,
	input  score_pkg::target_mask_t catch_right,
	input  score_pkg::lane_state_t  lane_state_left,
	input  score_pkg::lane_state_t  lane_state_right,
	input  score_pkg::score_t     target_score,
	output score_pkg::score_t     score_left,
	output score_pkg::score_t     score_right,
	output score_pkg::score_t     total_score,
	output score_pkg::bcd_score_t digits_left,
	output score_pkg::bcd_score_t digits_right,
	output score_pkg::bcd_score_t digits_total,
	output logic                  show_fail
);
	import score_pkg::*;

	logic        award_valid_left;
	logic        award_scores_left;
	target_idx_t award_idx_left;
	logic        award_valid_right;
	logic        award_scores_right;
	target_idx_t award_idx_right;

	////////////////////////////////
	// left side
	////////////////////////////////
	catch_decode i_decode_left (
		.Clk          (Clk),
		.reset        (reset),
		.round_start  (round_start),
		.catches      (catch_left),
		.lane_state   (lane_state_left),
		.award_valid  (award_valid_left),
		.award_idx    (award_idx_left),
		.award_scores (award_scores_left)
	);

	side_score i_score_left (
		.Clk           (Clk),
		.reset         (reset),
		.round_start   (round_start),
		.double_active (double_active),
		.award_valid   (award_valid_left),
		.award_scores  (award_scores_left),
		.award_idx     (award_idx_left),
		.score         (score_left)
	);

	////////////////////////////////
	// right side
	////////////////////////////////
	catch_decode i_decode_right (
		.Clk          (Clk),
		.reset        (reset),
		.round_start  (round_start),
		.catches      (catch_right),
		.lane_state   (lane_state_right),
		.award_valid  (award_valid_right),
		.award_idx    (award_idx_right),
		.award_scores (award_scores_right)
	);

	side_score i_score_right (
		.Clk           (Clk),
		.reset         (reset),
		.round_start   (round_start),
		.double_active (double_active),
		.award_valid   (award_valid_right),
		.award_scores  (award_scores_right),
		.award_idx     (award_idx_right),
		.score         (score_right)
	);

	////////////////////////////////
	// total, verdict, display
	////////////////////////////////
	score_result i_result (
		.Clk          (Clk),
		.reset        (reset),
		.round_start  (round_start),
		.time_end     (time_end),
		.score_left   (score_left),
		.score_right  (score_right),
		.target_score (target_score),
		.total_score  (total_score),
		.show_fail    (show_fail)
	);

	// digits trail their score by two edges
	score_digits i_digits_left (
		.Clk    (Clk),
		.score  (score_left),
		.digits (digits_left)
	);

	score_digits i_digits_right (
		.Clk    (Clk),
		.score  (score_right),
		.digits (digits_right)
	);

	score_digits i_digits_total (
		.Clk    (Clk),
		.score  (total_score),
		.digits (digits_total)
	);

endmodule

`default_nettype wire

/* verification/score_keeper_tb.sv */
`default_nettype none

module score_keeper_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import score_pkg::*;

	localparam int REC_FIELDS = 16;
	localparam int REC_MAX = 64;
	localparam int RESET_CYCLES = 3;
	localparam int DRAIN_LIMIT = 16;
	// age of a record when its last output is due
	localparam int LAST_AGE = 4;

	// columns of a record in the test file
	localparam int F_GAP = 0;
	localparam int F_RS = 1;
	localparam int F_DOUBLE = 2;
	localparam int F_TIME_END = 3;
	localparam int F_LANE_L = 4;
	localparam int F_LANE_R = 5;
	localparam int F_CATCH_L = 6;
	localparam int F_CATCH_R = 7;
	localparam int F_TARGET = 8;
	localparam int F_EXP_L = 9;
	localparam int F_EXP_R = 10;
	localparam int F_EXP_FAIL = 11;
	localparam int F_EXP_TOTAL = 12;
	localparam int F_DIG_L = 13;
	localparam int F_DIG_R = 14;
	localparam int F_DIG_T = 15;

	logic         Clk = 1'b0;
	logic         reset;
	logic         round_start;
	logic         double_active;
	logic         time_end;
	target_mask_t catch_left;
	target_mask_t catch_right;
	lane_state_t  lane_state_left;
	lane_state_t  lane_state_right;
	score_t       target_score;
	score_t       score_left;
	score_t       score_right;
	score_t       total_score;
	bcd_score_t   digits_left;
	bcd_score_t   digits_right;
	bcd_score_t   digits_total;
	logic         show_fail;

	score_t test_mem [REC_MAX*REC_FIELDS];
	int     rec_cycle [REC_MAX];
	int     rec_errors [REC_MAX];
	int     cycle;
	int     applied_count;
	int     first_open;
	int     error_count;
	int     check_count;
	int     failed_tests;

	always #10 Clk = ~Clk;

	score_keeper_top i_dut (
		.Clk              (Clk),
		.reset            (reset),
		.round_start      (round_start),
		.double_active    (double_active),
		.time_end         (time_end),
		.catch_left       (catch_left),
		.catch_right      (catch_right),
		.lane_state_left  (lane_state_left),
		.lane_state_right (lane_state_right),
		.target_score     (target_score),
		.score_left       (score_left),
		.score_right      (score_right),
		.total_score      (total_score),
		.digits_left      (digits_left),
		.digits_right     (digits_right),
		.digits_total     (digits_total),
		.show_fail        (show_fail)
	);

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_score(input int rec, input string what, input score_t got,
			input score_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			rec_errors[rec]++;
			$display("[ERROR] t=%0d ns: test %0d %s is %0d, expected %0d",
				$time, rec, what, got, expected);
		end
	endtask

	task automatic check_digits(input int rec, input string what, input bcd_score_t got,
			input bcd_score_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			rec_errors[rec]++;
			$display("[ERROR] t=%0d ns: test %0d %s is %05h, expected %05h",
				$time, rec, what, got, expected);
		end
	endtask

	task automatic check_flag(input int rec, input string what, input logic got,
			input logic expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			rec_errors[rec]++;
			$display("[ERROR] t=%0d ns: test %0d %s is %b, expected %b",
				$time, rec, what, got, expected);
		end
	endtask

	task automatic report_test(input int rec);
		if (rec_errors[rec] == 0) begin
			$display("test %0d: ok", rec);
		end else begin
			failed_tests++;
			$display("test %0d: %0d mismatches", rec, rec_errors[rec]);
		end
	endtask

	// each output is checked at its own latency from the sampling edge
	task automatic run_due_checks();
		int r;
		int age;
		int b;
		for (r = first_open; r < applied_count; r++) begin
			age = cycle - rec_cycle[r];
			b = r * REC_FIELDS;
			if (age == 1) begin
				check_score(r, "score_left", score_left, test_mem[b + F_EXP_L]);
				check_score(r, "score_right", score_right, test_mem[b + F_EXP_R]);
				check_flag(r, "show_fail", show_fail, test_mem[b + F_EXP_FAIL][0]);
			end else if (age == 2) begin
				check_score(r, "total_score", total_score, test_mem[b + F_EXP_TOTAL]);
			end else if (age == 3) begin
				check_digits(r, "digits_left", digits_left, test_mem[b + F_DIG_L]);
				check_digits(r, "digits_right", digits_right, test_mem[b + F_DIG_R]);
			end else if (age == LAST_AGE) begin
				check_digits(r, "digits_total", digits_total, test_mem[b + F_DIG_T]);
				report_test(r);
			end
		end
		while (first_open < applied_count && cycle - rec_cycle[first_open] >= LAST_AGE) begin
			first_open++;
		end
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////
	task automatic next_cycle();
		@(posedge Clk);
		cycle++;
		@(negedge Clk);
		run_due_checks();
	endtask

	task automatic apply_record(input int r);
		int b;
		b = r * REC_FIELDS;
		round_start = test_mem[b + F_RS][0];
		double_active = test_mem[b + F_DOUBLE][0];
		time_end = test_mem[b + F_TIME_END][0];
		lane_state_left = lane_state_t'(test_mem[b + F_LANE_L][2:0]);
		lane_state_right = lane_state_t'(test_mem[b + F_LANE_R][2:0]);
		catch_left = test_mem[b + F_CATCH_L][NUM_TARGETS-1:0];
		catch_right = test_mem[b + F_CATCH_R][NUM_TARGETS-1:0];
		target_score = test_mem[b + F_TARGET];
		rec_cycle[r] = cycle;
		applied_count = r + 1;
	endtask

	// unread words keep an address-based fill that no gap field can hold
	function automatic score_t fill_word(input int addr);
		return score_t'('hf0000) | score_t'(addr);
	endfunction

	function automatic int count_records();
		int n;
		n = 0;
		while (n < REC_MAX && test_mem[n * REC_FIELDS + F_GAP]
				!= fill_word(n * REC_FIELDS + F_GAP)) begin
			n++;
		end
		return n;
	endfunction

	initial begin
		int   num_records;
		int   gap;
		int   drain;
		logic drain_timeout;

		reset = 1'b1;
		round_start = 1'b0;
		double_active = 1'b0;
		time_end = 1'b0;
		catch_left = '0;
		catch_right = '0;
		lane_state_left = LANE_SCORING;
		lane_state_right = LANE_SCORING;
		target_score = '0;
		cycle = 0;
		applied_count = 0;
		first_open = 0;
		error_count = 0;
		check_count = 0;
		failed_tests = 0;
		drain_timeout = 1'b0;
		for (int i = 0; i < REC_MAX; i++) begin
			rec_errors[i] = 0;
			rec_cycle[i] = 0;
		end
		for (int i = 0; i < REC_MAX * REC_FIELDS; i++) begin
			test_mem[i] = fill_word(i);
		end
		$readmemh("verification/score_tests.txt", test_mem);
		num_records = count_records();
		void'($urandom(35));

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge Clk);
		end
		@(negedge Clk);
		reset = 1'b0;

		for (int r = 0; r < num_records; r++) begin
			apply_record(r);
			next_cycle();
			// idle cycles only after records that leave nothing pending
			if (test_mem[r * REC_FIELDS + F_GAP][0]) begin
				gap = $urandom % 4;
				for (int g = 0; g < gap; g++) begin
					next_cycle();
				end
			end
		end

		// flush the digit pipeline
		drain = 0;
		while (first_open < applied_count && drain < DRAIN_LIMIT) begin
			next_cycle();
			drain++;
		end
		drain_timeout = (first_open < applied_count);

		if (num_records == 0) begin
			$display("no test records could be read from verification/score_tests.txt");
		end
		if (drain_timeout) begin
			$display("timeout: checks still pending after %0d drain cycles", DRAIN_LIMIT);
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			num_records, failed_tests, check_count, error_count);
		if (error_count == 0 && failed_tests == 0 && !drain_timeout && num_records > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/score_tests.txt */
// hex: gap rs dbl tend laneL laneR catchL catchR target, then expected
// scoreL scoreR fail total digitsL digitsR digitsT (gap 1 allows idle cycles after)
// round one, every target on both sides, catches held high
1 0 1 0 0 0 0001 2000 00000 001f4 00014 0 00208 00500 00020 00520
1 0 1 0 0 0 0003 3000 00000 003e8 00028 0 00410 01000 00040 01040
1 0 1 0 0 0 0007 3800 00000 004e2 0005a 0 0053c 01250 00090 01340
1 0 1 0 0 0 000f 3c00 00000 005dc 0008c 0 00668 01500 00140 01640
1 0 1 0 0 0 001f 3e00 00000 00640 000a0 0 006e0 01600 00160 01760
1 0 1 0 0 0 003f 3f00 00000 006a4 002f8 0 0099c 01700 00760 02460
1 0 1 0 0 0 007f 3f80 00000 006d6 0032a 0 00a00 01750 00810 02560
1 0 1 0 0 0 00ff 3fc0 00000 00708 0035c 0 00a64 01800 00860 02660
1 0 1 0 0 0 01ff 3fe0 00000 00960 003c0 0 00d20 02400 00960 03360
1 0 1 0 0 0 03ff 3ff0 00000 00974 00424 0 00d98 02420 01060 03480
1 0 1 0 0 0 07ff 3ff8 00000 009a6 0051e 0 00ec4 02470 01310 03780
1 0 1 0 0 0 0fff 3ffc 00000 009d8 00618 0 00ff0 02520 01560 04080
1 0 1 0 0 0 1fff 3ffe 00000 009ec 0080c 0 011f8 02540 02060 04600
1 0 1 0 0 0 3fff 3fff 00000 00a00 00a00 0 01400 02560 02560 05120
// settle, then end of time against several targets
1 0 1 0 0 0 3fff 3fff 00000 00a00 00a00 0 01400 02560 02560 05120
1 0 1 1 0 0 3fff 3fff 01401 00a00 00a00 1 01400 02560 02560 05120
1 0 1 0 0 0 3fff 3fff 01401 00a00 00a00 0 01400 02560 02560 05120
1 0 1 1 0 0 3fff 3fff 01400 00a00 00a00 0 01400 02560 02560 05120
1 0 1 1 0 0 3fff 3fff 01000 00a00 00a00 0 01400 02560 02560 05120
// new round, held catches ignored
0 1 1 0 0 0 3fff 3fff 00000 00000 00000 0 00000 00000 00000 00000
// blocked left uses target 8, unnamed lane on the right does not
1 0 1 0 3 5 0100 0100 00000 00000 00000 0 00000 00000 00000 00000
1 0 1 0 0 0 0100 0100 00000 00000 00258 0 00258 00000 00600 00600
// double mode off uses target 0 without points
1 0 0 0 0 0 0001 0001 00000 00000 00258 0 00258 00000 00600 00600
1 0 1 0 0 0 0001 0001 00000 00000 00258 0 00258 00000 00600 00600
// several targets at once, lowest first, one per cycle
0 0 1 0 0 0 0016 0006 00000 001f4 0044c 0 00640 00500 01100 01600
0 0 1 0 0 0 0016 0006 00000 002ee 00546 0 00834 00750 01350 02100
1 0 1 0 0 0 0016 0006 00000 00352 00546 0 00898 00850 01350 02200
// score change right before a round start, total holds
0 0 1 0 0 0 0036 2006 00000 003b6 0055a 0 00898 00950 01370 02200
0 1 1 0 0 0 0036 2006 00000 00000 00000 0 00000 00000 00000 00000
// targets re-armed
0 0 1 0 0 0 0036 2006 00000 001f4 001f4 0 003e8 00500 00500 01000
0 0 1 0 0 0 0036 2006 00000 002ee 002ee 0 005dc 00750 00750 01500
0 0 1 0 0 0 0036 2006 00000 00352 00302 0 00654 00850 00770 01620
1 0 1 0 0 0 0036 2006 00000 003b6 00302 0 006b8 00950 00770 01720
1 0 1 0 0 0 0036 2006 00000 003b6 00302 0 006b8 00950 00770 01720
// verdict one below and equal, then time_end low
1 0 1 1 0 0 0036 2006 006b9 003b6 00302 1 006b8 00950 00770 01720
1 0 1 1 0 0 0036 2006 006b8 003b6 00302 0 006b8 00950 00770 01720
1 0 1 0 0 0 0036 2006 006b8 003b6 00302 0 006b8 00950 00770 01720

/* sources.f */
src/score_pkg.sv
src/catch_decode.sv
src/side_score.sv
src/score_result.sv
src/score_digits.sv
src/score_keeper_top.sv
verification/score_keeper_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the score keeper testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=score_keeper_sim

verilator --binary --timing \
	--timescale 1ns/1ps \
	-f sources.f \
	--top-module score_keeper_tb \
	--Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"

"./$BUILD_DIR/$SIM_BIN" | tee "$LOG_FILE"

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG_FILE"
	exit 1
fi
